// ==== hw/tti_pkg.sv ====
// TTI register map and shared types

package tti_pkg;

  localparam int unsigned CsrAddrWidth = 8;

  // Register offsets on the strobe bus
  localparam logic [CsrAddrWidth-1:0] TxDataPortAddr = 8'h00;
  localparam logic [CsrAddrWidth-1:0] RxDataPortAddr = 8'h04;
  localparam logic [CsrAddrWidth-1:0] ThldCtrlAddr   = 8'h08;
  localparam logic [CsrAddrWidth-1:0] StatusAddr     = 8'h0C;

  // Threshold control word, each field is 8 bits wide
  localparam int unsigned RxThldLsb = 0;
  localparam int unsigned TxThldLsb = 8;

  // Status word layout
  localparam int unsigned StatusRxEmpty    = 0;
  localparam int unsigned StatusRxFull     = 1;
  localparam int unsigned StatusTxEmpty    = 2;
  localparam int unsigned StatusTxFull     = 3;
  localparam int unsigned StatusRxTrig     = 4;
  localparam int unsigned StatusTxTrig     = 5;
  localparam int unsigned StatusRxCountLsb = 8;
  localparam int unsigned StatusTxCountLsb = 16;

  // Register targeted by a read strobe
  typedef enum logic [1:0] {
    RdSelNone,
    RdSelRxData,
    RdSelThld,
    RdSelStatus
  } rd_sel_e;

endpackage : tti_pkg

// ==== hw/tti_csr_decode.sv ====
// TTI register decoder

`timescale 1ns/1ps

module tti_csr_decode #(
  parameter int unsigned DataWidth  = 32,
  parameter int unsigned QueueDepth = 8,
  localparam int unsigned CntWidth  = $clog2(QueueDepth + 1)
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,

  input  logic [tti_pkg::CsrAddrWidth-1:0]  csr_addr_i,
  input  logic                              csr_wr_i,
  input  logic                              csr_rd_i,
  input  logic [DataWidth-1:0]              csr_wdata_i,

  output logic                              tx_push_o,  // Write request to the TX queue
  output logic [DataWidth-1:0]              tx_wdata_o,
  output logic                              rx_pop_o,   // Read request to the RX queue
  output tti_pkg::rd_sel_e                  rd_sel_o,
  output logic [CntWidth-1:0]               rx_thld_o,
  output logic [CntWidth-1:0]               tx_thld_o,
  output logic                              thld_update_o
);
  import tti_pkg::*;

  logic                thld_wr;
  logic                thld_wr_q;   // First stage of the update delay
  logic                thld_upd_q;  // Second stage, drives the pulse
  logic [CntWidth-1:0] rx_thld_q;
  logic [CntWidth-1:0] tx_thld_q;

  // Data port accesses map straight onto queue handshakes
  assign tx_push_o  = csr_wr_i && (csr_addr_i == TxDataPortAddr);
  assign tx_wdata_o = csr_wdata_i;
  assign rx_pop_o   = csr_rd_i && (csr_addr_i == RxDataPortAddr);

  assign thld_wr = csr_wr_i && (csr_addr_i == ThldCtrlAddr);

  always_comb begin
    rd_sel_o = RdSelNone;
    if (csr_rd_i) begin
      case (csr_addr_i)
        RxDataPortAddr: rd_sel_o = RdSelRxData;
        ThldCtrlAddr:   rd_sel_o = RdSelThld;
        StatusAddr:     rd_sel_o = RdSelStatus;
        default:        rd_sel_o = RdSelNone;  // TX port and holes read as zero
      endcase
    end
  end

  // Both thresholds are taken from one write, upper field bits are dropped
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_thld_q <= '0;
      tx_thld_q <= '0;
    end else if (thld_wr) begin
      rx_thld_q <= csr_wdata_i[RxThldLsb +: CntWidth];
      tx_thld_q <= csr_wdata_i[TxThldLsb +: CntWidth];
    end
  end

  // The update pulse trails the write strobe by two flops
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      thld_wr_q  <= 1'b0;
      thld_upd_q <= 1'b0;
    end else begin
      thld_wr_q  <= thld_wr;
      thld_upd_q <= thld_wr_q;
    end
  end

  assign rx_thld_o     = rx_thld_q;
  assign tx_thld_o     = tx_thld_q;
  assign thld_update_o = thld_upd_q;

endmodule : tti_csr_decode

// ==== hw/tti_queue.sv ====
// TTI data queue

`timescale 1ns/1ps

module tti_queue #(
  parameter int unsigned DataWidth  = 32,
  parameter int unsigned QueueDepth = 8,
  localparam int unsigned CntWidth  = $clog2(QueueDepth + 1),
  localparam int unsigned PtrWidth  = (QueueDepth > 1) ? $clog2(QueueDepth) : 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Write side
  input  logic                 wvalid_i,
  output logic                 wready_o,
  input  logic [DataWidth-1:0] wdata_i,

  // Read side
  output logic                 rvalid_o,
  input  logic                 rready_i,
  output logic [DataWidth-1:0] rdata_o,

  output logic [CntWidth-1:0]  count_o,
  output logic                 full_o,
  output logic                 empty_o
);

  logic [DataWidth-1:0] mem_q [QueueDepth];
  logic [PtrWidth-1:0]  wr_ptr_q;
  logic [PtrWidth-1:0]  rd_ptr_q;
  logic [CntWidth-1:0]  count_q;
  logic                 push;
  logic                 pop;

  assign full_o  = (count_q == CntWidth'(QueueDepth));
  assign empty_o = (count_q == '0);

  assign wready_o = !full_o;
  assign rvalid_o = !empty_o;
  assign rdata_o  = mem_q[rd_ptr_q];  // Head word holds until it is taken
  assign count_o  = count_q;

  assign push = wvalid_i && wready_o;
  assign pop  = rvalid_o && rready_i;

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
    end else if (push) begin
      if (wr_ptr_q == PtrWidth'(QueueDepth - 1)) begin
        wr_ptr_q <= '0;
      end else begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
    end else if (pop) begin
      if (rd_ptr_q == PtrWidth'(QueueDepth - 1)) begin
        rd_ptr_q <= '0;
      end else begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // A push and a pop in the same cycle leave the count unchanged
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule : tti_queue

// ==== hw/tti_csr_result.sv ====
// TTI read data, acknowledge and triggers

`timescale 1ns/1ps

module tti_csr_result #(
  parameter int unsigned DataWidth  = 32,
  parameter int unsigned QueueDepth = 8,
  localparam int unsigned CntWidth  = $clog2(QueueDepth + 1)
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  logic                 csr_wr_i,
  input  logic                 csr_rd_i,
  input  tti_pkg::rd_sel_e     rd_sel_i,

  input  logic [DataWidth-1:0] rx_rdata_i,
  input  logic                 rx_rvalid_i,
  input  logic [CntWidth-1:0]  rx_count_i,
  input  logic                 rx_full_i,
  input  logic                 rx_empty_i,
  input  logic [CntWidth-1:0]  tx_count_i,
  input  logic                 tx_full_i,
  input  logic                 tx_empty_i,
  input  logic [CntWidth-1:0]  rx_thld_i,
  input  logic [CntWidth-1:0]  tx_thld_i,

  output logic [DataWidth-1:0] csr_rdata_o,
  output logic                 csr_ack_o,
  output logic                 rx_ready_thld_trig_o,
  output logic                 tx_ready_thld_trig_o
);
  import tti_pkg::*;

  logic [CntWidth-1:0]  tx_free;
  logic [DataWidth-1:0] status_word;
  logic [DataWidth-1:0] thld_word;
  logic [DataWidth-1:0] rdata_d;
  logic                 ack_q;

  // A zero threshold keeps the trigger off
  assign tx_free = CntWidth'(QueueDepth) - tx_count_i;
  assign rx_ready_thld_trig_o = (rx_thld_i != '0) && (rx_count_i >= rx_thld_i);
  assign tx_ready_thld_trig_o = (tx_thld_i != '0) && (tx_free >= tx_thld_i);

  always_comb begin
    status_word = '0;
    status_word[StatusRxEmpty] = rx_empty_i;
    status_word[StatusRxFull]  = rx_full_i;
    status_word[StatusTxEmpty] = tx_empty_i;
    status_word[StatusTxFull]  = tx_full_i;
    status_word[StatusRxTrig]  = rx_ready_thld_trig_o;
    status_word[StatusTxTrig]  = tx_ready_thld_trig_o;
    status_word[StatusRxCountLsb +: CntWidth] = rx_count_i;
    status_word[StatusTxCountLsb +: CntWidth] = tx_count_i;

    thld_word = '0;
    thld_word[RxThldLsb +: CntWidth] = rx_thld_i;
    thld_word[TxThldLsb +: CntWidth] = tx_thld_i;
  end

  always_comb begin
    case (rd_sel_i)
      RdSelRxData: rdata_d = rx_rvalid_i ? rx_rdata_i : '0;  // Empty queue reads zero
      RdSelThld:   rdata_d = thld_word;
      RdSelStatus: rdata_d = status_word;
      default:     rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= csr_wr_i || csr_rd_i;  // Every strobe is answered on the next cycle
    end
  end

  always_ff @(posedge clk_i) begin
    csr_rdata_o <= rdata_d;
  end

  assign csr_ack_o = ack_q;

endmodule : tti_csr_result

// ==== hw/tti_top.sv ====
// I3C target transaction interface

`timescale 1ns/1ps

module tti_top #(
  parameter int unsigned DataWidth  = 32,
  parameter int unsigned QueueDepth = 8
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // Register strobe bus
  input  logic [tti_pkg::CsrAddrWidth-1:0] csr_addr_i,
  input  logic                             csr_wr_i,
  input  logic                             csr_rd_i,
  input  logic [DataWidth-1:0]             csr_wdata_i,
  output logic [DataWidth-1:0]             csr_rdata_o,
  output logic                             csr_ack_o,

  // Bus side
  input  logic                             rx_wvalid_i,
  input  logic [DataWidth-1:0]             rx_wdata_i,
  output logic                             rx_wready_o,
  output logic                             tx_rvalid_o,
  output logic [DataWidth-1:0]             tx_rdata_o,
  input  logic                             tx_rready_i,

  output logic                             thld_update_o,
  output logic                             rx_ready_thld_trig_o,
  output logic                             tx_ready_thld_trig_o
);
  import tti_pkg::*;

  localparam int unsigned CntWidth = $clog2(QueueDepth + 1);

  logic                 tx_push;
  logic [DataWidth-1:0] tx_wdata;
  logic                 rx_pop;
  rd_sel_e              rd_sel;
  logic [CntWidth-1:0]  rx_thld;
  logic [CntWidth-1:0]  tx_thld;

  logic                 rx_rvalid;
  logic [DataWidth-1:0] rx_rdata;
  logic [CntWidth-1:0]  rx_count;
  logic                 rx_full;
  logic                 rx_empty;
  logic [CntWidth-1:0]  tx_count;
  logic                 tx_full;
  logic                 tx_empty;

  tti_csr_decode #(
    .DataWidth (DataWidth),
    .QueueDepth(QueueDepth)
  ) i_csr_decode (
    .clk_i,
    .rst_ni,
    .csr_addr_i,
    .csr_wr_i,
    .csr_rd_i,
    .csr_wdata_i,
    .tx_push_o    (tx_push),
    .tx_wdata_o   (tx_wdata),
    .rx_pop_o     (rx_pop),
    .rd_sel_o     (rd_sel),
    .rx_thld_o    (rx_thld),
    .tx_thld_o    (tx_thld),
    .thld_update_o
  );

  // Filled by the bus, drained through the RX data port
  tti_queue #(
    .DataWidth (DataWidth),
    .QueueDepth(QueueDepth)
  ) i_rx_queue (
    .clk_i,
    .rst_ni,
    .wvalid_i(rx_wvalid_i),
    .wready_o(rx_wready_o),
    .wdata_i (rx_wdata_i),
    .rvalid_o(rx_rvalid),
    .rready_i(rx_pop),
    .rdata_o (rx_rdata),
    .count_o (rx_count),
    .full_o  (rx_full),
    .empty_o (rx_empty)
  );

  tti_queue #(
    .DataWidth (DataWidth),
    .QueueDepth(QueueDepth)
  ) i_tx_queue (
    .clk_i,
    .rst_ni,
    .wvalid_i(tx_push),
    .wready_o(),           // Register writes to a full queue are dropped
    .wdata_i (tx_wdata),
    .rvalid_o(tx_rvalid_o),
    .rready_i(tx_rready_i),
    .rdata_o (tx_rdata_o),
    .count_o (tx_count),
    .full_o  (tx_full),
    .empty_o (tx_empty)
  );

  tti_csr_result #(
    .DataWidth (DataWidth),
    .QueueDepth(QueueDepth)
  ) i_csr_result (
    .clk_i,
    .rst_ni,
    .csr_wr_i,
    .csr_rd_i,
    .rd_sel_i   (rd_sel),
    .rx_rdata_i (rx_rdata),
    .rx_rvalid_i(rx_rvalid),
    .rx_count_i (rx_count),
    .rx_full_i  (rx_full),
    .rx_empty_i (rx_empty),
    .tx_count_i (tx_count),
    .tx_full_i  (tx_full),
    .tx_empty_i (tx_empty),
    .rx_thld_i  (rx_thld),
    .tx_thld_i  (tx_thld),
    .csr_rdata_o,
    .csr_ack_o,
    .rx_ready_thld_trig_o,
    .tx_ready_thld_trig_o
  );

endmodule : tti_top

// ==== verification/tti_checker.sv ====
// TTI protocol assertions

`timescale 1ns/1ps

module tti_checker (
  input logic                             clk_i,
  input logic                             rst_ni,
  input logic [tti_pkg::CsrAddrWidth-1:0] csr_addr_i,
  input logic                             csr_wr_i,
  input logic                             csr_rd_i,
  input logic                             csr_ack_i,
  input logic                             thld_update_i,
  input logic                             tx_rvalid_i,
  input logic                             rx_wready_i
);
  import tti_pkg::*;

  int unsigned fail_cnt = 0;
  logic        thld_wr;

  assign thld_wr = csr_wr_i && (csr_addr_i == ThldCtrlAddr);

  // One acknowledge per strobe, exactly one cycle later
  ack_follows_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_ack_i == $past(csr_wr_i || csr_rd_i))
    else begin
      fail_cnt++;
      $error("csr_ack_o does not follow the register strobes by one cycle");
    end

  thld_pulse_delay: assert property (@(posedge clk_i) disable iff (!rst_ni)
    thld_update_i == $past(thld_wr, 2))
    else begin
      fail_cnt++;
      $error("thld_update_o is not two cycles after the threshold write");
    end

  reset_outputs: assert property (@(posedge clk_i)
    !rst_ni |-> (!csr_ack_i && !thld_update_i && !tx_rvalid_i && rx_wready_i))
    else begin
      fail_cnt++;
      $error("Outputs do not hold their reset values during reset");
    end

endmodule : tti_checker

bind tti_top tti_checker i_checker (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .csr_addr_i   (csr_addr_i),
  .csr_wr_i     (csr_wr_i),
  .csr_rd_i     (csr_rd_i),
  .csr_ack_i    (csr_ack_o),
  .thld_update_i(thld_update_o),
  .tx_rvalid_i  (tx_rvalid_o),
  .rx_wready_i  (rx_wready_o)
);

// ==== verification/tti_scoreboard.sv ====
// TTI scoreboard

`timescale 1ns/1ps

module tti_scoreboard #(
  parameter int unsigned DataWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 csr_ack_i,
  input  logic [DataWidth-1:0] csr_rdata_i,
  input  logic                 rx_wready_i,
  input  logic                 tx_rvalid_i,
  input  logic                 tx_rready_i,
  input  logic [DataWidth-1:0] tx_rdata_i,
  input  logic                 rx_trig_i,
  input  logic                 tx_trig_i,
  input  logic                 exp_rd_valid_i,  // High in the acknowledge cycle of a read
  input  logic                 exp_status_i,    // The pending read targets the status word
  input  logic [DataWidth-1:0] exp_rdata_i,
  input  logic [DataWidth-1:0] exp_tx_data_i,
  output int unsigned          check_cnt_o,
  output int unsigned          rd_err_cnt_o,
  output int unsigned          tx_err_cnt_o
);
  import tti_pkg::*;

  int unsigned check_cnt  = 0;
  int unsigned rd_err_cnt = 0;
  int unsigned tx_err_cnt = 0;

  // Inputs move just after the rising edge, so the falling edge sees stable values
  always @(negedge clk_i) begin
    if (rst_ni && exp_rd_valid_i) begin
      check_cnt = check_cnt + 1;
      if (!csr_ack_i) begin
        rd_err_cnt = rd_err_cnt + 1;
        $display("No acknowledge in the cycle after a read strobe at %0t", $time);
      end else if (csr_rdata_i !== exp_rdata_i) begin
        rd_err_cnt = rd_err_cnt + 1;
        $display("FAIL at %0t: read data %h, expected %h", $time, csr_rdata_i, exp_rdata_i);
      end

      // Port flags and triggers must agree with the expected status word
      if (exp_status_i) begin
        check_cnt = check_cnt + 1;
        if (rx_trig_i !== exp_rdata_i[StatusRxTrig]) begin
          rd_err_cnt = rd_err_cnt + 1;
          $display("FAIL at %0t: RX trigger %b, expected %b", $time, rx_trig_i,
                   exp_rdata_i[StatusRxTrig]);
        end
        if (tx_trig_i !== exp_rdata_i[StatusTxTrig]) begin
          rd_err_cnt = rd_err_cnt + 1;
          $display("FAIL at %0t: TX trigger %b, expected %b", $time, tx_trig_i,
                   exp_rdata_i[StatusTxTrig]);
        end
        if (rx_wready_i !== !exp_rdata_i[StatusRxFull]) begin
          rd_err_cnt = rd_err_cnt + 1;
          $display("FAIL at %0t: RX ready %b, expected %b", $time, rx_wready_i,
                   !exp_rdata_i[StatusRxFull]);
        end
        if (tx_rvalid_i !== !exp_rdata_i[StatusTxEmpty]) begin
          rd_err_cnt = rd_err_cnt + 1;
          $display("FAIL at %0t: TX valid %b, expected %b", $time, tx_rvalid_i,
                   !exp_rdata_i[StatusTxEmpty]);
        end
      end
    end

    // A TX handshake completes at the next rising edge
    if (rst_ni && tx_rvalid_i && tx_rready_i) begin
      check_cnt = check_cnt + 1;
      if (tx_rdata_i !== exp_tx_data_i) begin
        tx_err_cnt = tx_err_cnt + 1;
        $display("FAIL at %0t: TX data %h, expected %h", $time, tx_rdata_i, exp_tx_data_i);
      end
    end
  end

  assign check_cnt_o  = check_cnt;
  assign rd_err_cnt_o = rd_err_cnt;
  assign tx_err_cnt_o = tx_err_cnt;

endmodule : tti_scoreboard

// ==== verification/tti_tb.sv ====
// TTI testbench

`timescale 1ns/1ps

module tti_tb;
  import tti_pkg::*;

  localparam int DataWidth  = 32;
  localparam int QueueDepth = 8;
  localparam int MaxOps     = 64;
  localparam int IdxWidth   = $clog2(4 * MaxOps);

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic [CsrAddrWidth-1:0] csr_addr;
  logic                    csr_wr;
  logic                    csr_rd;
  logic [DataWidth-1:0]    csr_wdata;
  logic [DataWidth-1:0]    csr_rdata;
  logic                    csr_ack;
  logic                    rx_wvalid;
  logic [DataWidth-1:0]    rx_wdata;
  logic                    rx_wready;
  logic                    tx_rvalid;
  logic [DataWidth-1:0]    tx_rdata;
  logic                    tx_rready;
  logic                    thld_update;
  logic                    rx_trig;
  logic                    tx_trig;

  // Expected values handed to the scoreboard
  logic                    exp_rd_valid;
  logic                    exp_status;
  logic [DataWidth-1:0]    exp_rdata;
  logic [DataWidth-1:0]    exp_tx_data;
  int unsigned             check_cnt;
  int unsigned             rd_err_cnt;
  int unsigned             tx_err_cnt;

  // Four words per operation: op, address, write data, expected data
  logic [31:0] ops [4*MaxOps];
  int          n_ops      = 0;
  int unsigned bad_ops    = 0;
  bit          ops_loaded = 1'b0;
  logic [31:0] rng_state  = 32'h69b2;

  always #10 clk = ~clk;

  tti_top #(
    .DataWidth (DataWidth),
    .QueueDepth(QueueDepth)
  ) i_dut (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .csr_addr_i          (csr_addr),
    .csr_wr_i            (csr_wr),
    .csr_rd_i            (csr_rd),
    .csr_wdata_i         (csr_wdata),
    .csr_rdata_o         (csr_rdata),
    .csr_ack_o           (csr_ack),
    .rx_wvalid_i         (rx_wvalid),
    .rx_wdata_i          (rx_wdata),
    .rx_wready_o         (rx_wready),
    .tx_rvalid_o         (tx_rvalid),
    .tx_rdata_o          (tx_rdata),
    .tx_rready_i         (tx_rready),
    .thld_update_o       (thld_update),
    .rx_ready_thld_trig_o(rx_trig),
    .tx_ready_thld_trig_o(tx_trig)
  );

  tti_scoreboard #(
    .DataWidth(DataWidth)
  ) i_scoreboard (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .csr_ack_i     (csr_ack),
    .csr_rdata_i   (csr_rdata),
    .rx_wready_i   (rx_wready),
    .tx_rvalid_i   (tx_rvalid),
    .tx_rready_i   (tx_rready),
    .tx_rdata_i    (tx_rdata),
    .rx_trig_i     (rx_trig),
    .tx_trig_i     (tx_trig),
    .exp_rd_valid_i(exp_rd_valid),
    .exp_status_i  (exp_status),
    .exp_rdata_i   (exp_rdata),
    .exp_tx_data_i (exp_tx_data),
    .check_cnt_o   (check_cnt),
    .rd_err_cnt_o  (rd_err_cnt),
    .tx_err_cnt_o  (tx_err_cnt)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] op_field(input int op_idx, input int col);
    return ops[IdxWidth'(4 * op_idx + col)];
  endfunction

  task automatic write_csr(input logic [CsrAddrWidth-1:0] addr,
                           input logic [DataWidth-1:0] data);
    csr_addr  = addr;
    csr_wdata = data;
    csr_wr    = 1'b1;
    @(posedge clk);
    #1;
    csr_wr = 1'b0;
  endtask

  task automatic read_csr(input logic [CsrAddrWidth-1:0] addr,
                          input logic [DataWidth-1:0] expected);
    csr_addr = addr;
    csr_rd   = 1'b1;
    @(posedge clk);
    #1;
    csr_rd       = 1'b0;
    exp_rdata    = expected;
    exp_status   = (addr == StatusAddr);
    exp_rd_valid = 1'b1;  // Acknowledge cycle
    @(posedge clk);
    #1;
    exp_rd_valid = 1'b0;
  endtask

  task automatic push_rx_word(input logic [DataWidth-1:0] data);
    logic taken;
    rx_wdata  = data;
    rx_wvalid = 1'b1;
    do begin
      @(negedge clk);
      taken = rx_wready;
      @(posedge clk);
      #1;
    end while (!taken);
    rx_wvalid = 1'b0;
  endtask

  // The consumer takes the word only on cycles the generator allows
  task automatic pop_tx_word(input logic [DataWidth-1:0] expected);
    logic taken;
    exp_tx_data = expected;
    do begin
      rng_state = xorshift32(rng_state);
      tx_rready = rng_state[7];
      @(negedge clk);
      taken = tx_rvalid && tx_rready;
      @(posedge clk);
      #1;
    end while (!taken);
    tx_rready = 1'b0;
  endtask

  initial begin
    int unsigned errors;
    rst_n        = 1'b1;
    csr_addr     = '0;
    csr_wr       = 1'b0;
    csr_rd       = 1'b0;
    csr_wdata    = '0;
    rx_wvalid    = 1'b0;
    rx_wdata     = '0;
    tx_rready    = 1'b0;
    exp_rd_valid = 1'b0;
    exp_status   = 1'b0;
    exp_rdata    = '0;
    exp_tx_data  = '0;

    $readmemh("verification/tti_input.txt", ops);
    while (n_ops < MaxOps && op_field(n_ops, 0) != 32'hf) begin
      n_ops++;
    end
    ops_loaded = 1'b1;

    #1;
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (int i = 0; i < n_ops; i++) begin
      case (op_field(i, 0))
        32'h0: write_csr(CsrAddrWidth'(op_field(i, 1)), op_field(i, 2));
        32'h1: read_csr(CsrAddrWidth'(op_field(i, 1)), op_field(i, 3));
        32'h2: push_rx_word(op_field(i, 2));
        32'h3: pop_tx_word(op_field(i, 3));
        default: begin
          bad_ops++;
          $display("Unknown operation code %h in entry %0d of the input file",
                   op_field(i, 0), i);
        end
      endcase
    end
    repeat (2) @(posedge clk);

    errors = rd_err_cnt + tx_err_cnt + i_dut.i_checker.fail_cnt + bad_ops;
    $display("checks %0d, read errors %0d, TX errors %0d, assertion failures %0d, bad ops %0d",
             check_cnt, rd_err_cnt, tx_err_cnt, i_dut.i_checker.fail_cnt, bad_ops);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Budget of 100 cycles per operation
  initial begin
    wait (ops_loaded);
    repeat (n_ops * 100) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run hung", n_ops * 100);
    $display("sim failed");
    $finish;
  end

endmodule : tti_tb

// ==== verification/tti_input.txt ====
// Columns: op addr wdata expected, all hex
// op 0 register write, 1 register read, 2 RX bus push, 3 TX bus pop, f end of list
1 0C 00000000 00000005
0 00 a0000001 00000000
0 00 a0000002 00000000
0 00 a0000003 00000000
0 00 a0000004 00000000
0 00 a0000005 00000000
0 00 a0000006 00000000
0 00 a0000007 00000000
0 00 a0000008 00000000
0 00 a0000009 00000000
1 0C 00000000 00080009
3 00 00000000 a0000001
3 00 00000000 a0000002
3 00 00000000 a0000003
3 00 00000000 a0000004
3 00 00000000 a0000005
3 00 00000000 a0000006
3 00 00000000 a0000007
3 00 00000000 a0000008
0 08 00000503 00000000
1 08 00000000 00000503
2 00 b0000001 00000000
2 00 b0000002 00000000
2 00 b0000003 00000000
1 0C 00000000 00000334
2 00 b0000004 00000000
2 00 b0000005 00000000
2 00 b0000006 00000000
2 00 b0000007 00000000
2 00 b0000008 00000000
1 0C 00000000 00000836
1 04 00000000 b0000001
1 04 00000000 b0000002
1 04 00000000 b0000003
1 04 00000000 b0000004
1 04 00000000 b0000005
1 04 00000000 b0000006
1 04 00000000 b0000007
1 04 00000000 b0000008
1 04 00000000 00000000
1 0C 00000000 00000025
0 00 c0000001 00000000
0 00 c0000002 00000000
0 00 c0000003 00000000
0 00 c0000004 00000000
1 0C 00000000 00040001
3 00 00000000 c0000001
3 00 00000000 c0000002
3 00 00000000 c0000003
3 00 00000000 c0000004
f 00 00000000 00000000

// ==== tb.f ====
hw/tti_pkg.sv
hw/tti_csr_decode.sv
hw/tti_queue.sv
hw/tti_csr_result.sv
hw/tti_top.sv
verification/tti_checker.sv
verification/tti_scoreboard.sv
verification/tti_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the TTI testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tti_tb -f tb.f --Mdir obj_dir -o tti_sim

# A higher error limit lets failed assertions reach the closing summary
./obj_dir/tti_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "sim failed" sim.log; then
  exit 1
fi
